/* include/core_cfg.svh */
// Core configuration for register file, banking and reorder-buffer sizing
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Physical register file
`define PR_COUNT 16
`define LOG_PR_COUNT 4

// Bank is taken from the low bits of the register tag
`define PRF_BANK_COUNT 2

// Reorder buffer
`define ROB_ENTRIES 16
`define LOG_ROB_ENTRIES 4

`endif

/* src/core_types_pkg.sv */
// Core-wide data word, register tag and reorder-buffer index types
`default_nettype none
`include "core_cfg.svh"

package core_types_pkg;

  // Architectural data word
  typedef logic [31:0] word_t;

  // Physical register tag
  typedef logic [`LOG_PR_COUNT-1:0] pr_t;

  // Reorder-buffer slot index
  typedef logic [`LOG_ROB_ENTRIES-1:0] rob_idx_t;

endpackage

`default_nettype wire

/* src/alu_imm_pkg.sv */
// Immediate ALU operation codes and per-stage pipeline payloads
`default_nettype none

package alu_imm_pkg;

  // Low three bits follow funct3, bit 3 marks the arithmetic shift
  typedef enum logic [3:0] {
    ADDI  = 4'd0,
    SLLI  = 4'd1,
    SLTI  = 4'd2,
    SLTIU = 4'd3,
    XORI  = 4'd4,
    SRLI  = 4'd5,
    ORI   = 4'd6,
    ANDI  = 4'd7,
    SRAI  = 4'd13
  } alu_imm_op_e;

  // Held in the issue register
  typedef struct packed {
    alu_imm_op_e             op;
    logic [11:0]             imm12;
    logic                    a_is_zero;
    core_types_pkg::pr_t     dest_pr;
    core_types_pkg::rob_idx_t rob_index;
  } issue_pkt_t;

  // Held in the execute register, op and immediate kept for debug visibility
  typedef struct packed {
    alu_imm_op_e              op;
    logic [11:0]              imm12;
    core_types_pkg::word_t    result;
    core_types_pkg::pr_t      dest_pr;
    core_types_pkg::rob_idx_t rob_index;
  } exec_pkt_t;

  // Final writeback register
  typedef struct packed {
    core_types_pkg::word_t    data;
    core_types_pkg::pr_t      pr;
    core_types_pkg::rob_idx_t rob_index;
  } wb_pkt_t;

endpackage

`default_nettype wire

/* src/alu_pipe_if.sv */
// Stage-to-stage link carrying a valid bit, a payload and the global stall
`timescale 1ns/1ps
`default_nettype none

interface alu_pipe_if #(
  parameter type payload_t = logic
) ();

  logic     valid;
  payload_t payload;
  // Global freeze, same value on every link
  logic     stall;

  // Producing stage
  modport src (
    output valid,
    output payload,
    input  stall
  );

  // Consuming stage
  modport dst (
    input valid,
    input payload
  );

endinterface

`default_nettype wire

/* src/prf_banked.sv */
// Banked physical register file with one write port and one combinational read port
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module prf_banked (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  wr_en,
  input  core_types_pkg::pr_t   wr_pr,
  input  core_types_pkg::word_t wr_data,
  input  core_types_pkg::pr_t   rd_pr,
  output core_types_pkg::word_t rd_data
);

  localparam int BANK_BITS = $clog2(`PRF_BANK_COUNT);
  localparam int ROW_BITS  = `LOG_PR_COUNT - BANK_BITS;
  localparam int ROWS      = `PR_COUNT / `PRF_BANK_COUNT;

  core_types_pkg::word_t bank_mem [`PRF_BANK_COUNT][ROWS];

  logic [BANK_BITS-1:0] wr_bank;
  logic [BANK_BITS-1:0] rd_bank;
  logic [ROW_BITS-1:0]  wr_row;
  logic [ROW_BITS-1:0]  rd_row;

  // Low tag bits pick the bank, the rest pick the row
  assign wr_bank = wr_pr[BANK_BITS-1:0];
  assign wr_row  = wr_pr[`LOG_PR_COUNT-1:BANK_BITS];
  assign rd_bank = rd_pr[BANK_BITS-1:0];
  assign rd_row  = rd_pr[`LOG_PR_COUNT-1:BANK_BITS];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      for (int b = 0; b < `PRF_BANK_COUNT; b++) begin
        for (int r = 0; r < ROWS; r++) begin
          bank_mem[b][r] <= '0;
        end
      end
    end else if (wr_en) begin
      bank_mem[wr_bank][wr_row] <= wr_data;
    end
  end

  // No write-through, a write is visible on the following cycle
  assign rd_data = bank_mem[rd_bank][rd_row];

endmodule

`default_nettype wire

/* src/alu_imm_issue.sv */
// Issue stage accepting one instruction per cycle and requesting its source register
`timescale 1ns/1ps
`default_nettype none

module alu_imm_issue (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     issue_valid,
  input  alu_imm_pkg::alu_imm_op_e issue_op,
  input  logic [11:0]              issue_imm12,
  input  core_types_pkg::pr_t      issue_a_pr,
  input  logic                     issue_a_is_zero,
  input  core_types_pkg::pr_t      issue_dest_pr,
  input  core_types_pkg::rob_idx_t issue_rob_index,
  output logic                     issue_ready,
  output core_types_pkg::pr_t      rd_pr,
  alu_pipe_if.src                  out
);

  logic                    stall;
  logic                    accept;
  logic                    valid_q;
  alu_imm_pkg::issue_pkt_t pkt_q;
  core_types_pkg::pr_t     a_pr_q;

  assign stall       = out.stall;
  assign issue_ready = ~stall;
  assign accept      = issue_valid & issue_ready;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      // Bubble when nothing is accepted
      valid_q <= accept;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      pkt_q.op        <= issue_op;
      pkt_q.imm12     <= issue_imm12;
      pkt_q.a_is_zero <= issue_a_is_zero;
      pkt_q.dest_pr   <= issue_dest_pr;
      pkt_q.rob_index <= issue_rob_index;
      a_pr_q          <= issue_a_pr;
    end
  end

  // Register file read is driven from the stored tag
  assign rd_pr       = a_pr_q;
  assign out.valid   = valid_q;
  assign out.payload = pkt_q;

  // Frozen stage keeps its instruction and source tag
  a_issue_hold: assert property (@(posedge CLK) disable iff (!nRST)
    stall |=> $stable(pkt_q) && $stable(a_pr_q) && $stable(valid_q))
    else $error("issue stage changed during stall");

endmodule

`default_nettype wire

/* src/alu_imm_execute.sv */
// Execute stage selecting operand A, extending the immediate and running the ALU
`timescale 1ns/1ps
`default_nettype none

module alu_imm_execute (
  input  logic                  CLK,
  input  logic                  nRST,
  input  core_types_pkg::word_t rd_data,
  alu_pipe_if.dst               in,
  alu_pipe_if.src               out
);

  alu_imm_pkg::issue_pkt_t ipkt;
  alu_imm_pkg::exec_pkt_t  pkt_q;
  core_types_pkg::word_t   op_a;
  core_types_pkg::word_t   imm_ext;
  core_types_pkg::word_t   result;
  logic [4:0]              shamt;
  logic                    stall;
  logic                    valid_q;

  assign ipkt  = in.payload;
  assign stall = out.stall;

  assign op_a    = ipkt.a_is_zero ? '0 : rd_data;
  assign imm_ext = {{20{ipkt.imm12[11]}}, ipkt.imm12};
  // Shifts take only the low five immediate bits
  assign shamt   = ipkt.imm12[4:0];

  always_comb begin
    case (ipkt.op)
      alu_imm_pkg::ADDI:  result = op_a + imm_ext;
      alu_imm_pkg::SLTI:  result = {31'b0, $signed(op_a) < $signed(imm_ext)};
      alu_imm_pkg::SLTIU: result = {31'b0, op_a < imm_ext};
      alu_imm_pkg::XORI:  result = op_a ^ imm_ext;
      alu_imm_pkg::ORI:   result = op_a | imm_ext;
      alu_imm_pkg::ANDI:  result = op_a & imm_ext;
      alu_imm_pkg::SLLI:  result = op_a << shamt;
      alu_imm_pkg::SRLI:  result = op_a >> shamt;
      alu_imm_pkg::SRAI:  result = $signed(op_a) >>> shamt;
      default:            result = '0;
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= in.valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (!stall && in.valid) begin
      pkt_q.op        <= ipkt.op;
      pkt_q.imm12     <= ipkt.imm12;
      pkt_q.result    <= result;
      pkt_q.dest_pr   <= ipkt.dest_pr;
      pkt_q.rob_index <= ipkt.rob_index;
    end
  end

  assign out.valid   = valid_q;
  assign out.payload = pkt_q;

  // Issue side must only hand over defined immediate operations
  a_legal_op: assert property (@(posedge CLK) disable iff (!nRST)
    in.valid |-> ipkt.op inside {alu_imm_pkg::ADDI, alu_imm_pkg::SLTI, alu_imm_pkg::SLTIU,
                                 alu_imm_pkg::XORI, alu_imm_pkg::ORI, alu_imm_pkg::ANDI,
                                 alu_imm_pkg::SLLI, alu_imm_pkg::SRLI, alu_imm_pkg::SRAI})
    else $error("illegal ALU op code %0h", ipkt.op);

endmodule

`default_nettype wire

/* src/alu_imm_writeback.sv */
// Writeback stage holding the result until taken and generating the pipeline stall
`timescale 1ns/1ps
`default_nettype none

module alu_imm_writeback (
  input  logic                     CLK,
  input  logic                     nRST,
  alu_pipe_if.dst                  in,
  input  logic                     wb_ready,
  output logic                     wb_valid,
  output core_types_pkg::word_t    wb_data,
  output core_types_pkg::pr_t      wb_pr,
  output core_types_pkg::rob_idx_t wb_rob_index,
  output logic                     stall
);

  alu_imm_pkg::exec_pkt_t epkt;
  alu_imm_pkg::wb_pkt_t   pkt_q;
  logic                   valid_q;

  assign epkt = in.payload;

  // Held result not taken, so the whole pipe freezes
  assign stall = valid_q & ~wb_ready;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= in.valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (!stall && in.valid) begin
      pkt_q.data      <= epkt.result;
      pkt_q.pr        <= epkt.dest_pr;
      pkt_q.rob_index <= epkt.rob_index;
    end
  end

  assign wb_valid     = valid_q;
  assign wb_data      = pkt_q.data;
  assign wb_pr        = pkt_q.pr;
  assign wb_rob_index = pkt_q.rob_index;

  a_wb_valid_hold: assert property (@(posedge CLK) disable iff (!nRST)
    stall |=> wb_valid)
    else $error("wb_valid dropped before the result was taken");

  a_wb_data_hold: assert property (@(posedge CLK) disable iff (!nRST)
    stall |=> $stable(wb_data))
    else $error("wb_data changed during stall");

endmodule

`default_nettype wire

/* src/alu_imm_pipeline_sva.sv */
// Pipeline checker for writeback stability under stall and three-cycle tag pass-through
`timescale 1ns/1ps
`default_nettype none

module alu_imm_pipeline_sva (
  input logic                     CLK,
  input logic                     nRST,
  input logic                     issue_valid,
  input logic                     issue_ready,
  input core_types_pkg::pr_t      issue_dest_pr,
  input core_types_pkg::rob_idx_t issue_rob_index,
  input logic                     wb_valid,
  input logic                     wb_ready,
  input core_types_pkg::word_t    wb_data,
  input core_types_pkg::pr_t      wb_pr,
  input core_types_pkg::rob_idx_t wb_rob_index
);

  // History of accepted issues, index 2 is three cycles old
  logic                     hist_v   [3];
  core_types_pkg::pr_t      hist_pr  [3];
  core_types_pkg::rob_idx_t hist_rob [3];
  // Stall-free flags of the two most recent cycles
  logic [1:0]               free_q;

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      hist_v <= '{default: 1'b0};
      free_q <= '0;
    end else begin
      hist_v[0] <= issue_valid & issue_ready;
      hist_v[1] <= hist_v[0];
      hist_v[2] <= hist_v[1];
      free_q    <= {free_q[0], issue_ready};
    end
  end

  always_ff @(posedge CLK) begin
    hist_pr[0]  <= issue_dest_pr;
    hist_rob[0] <= issue_rob_index;
    for (int i = 1; i < 3; i++) begin
      hist_pr[i]  <= hist_pr[i-1];
      hist_rob[i] <= hist_rob[i-1];
    end
  end

  a_wb_stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (wb_valid && !wb_ready) |=> wb_valid && $stable(wb_data))
    else $error("writeback result not held under back-pressure");

  a_wb_tag_hold: assert property (@(posedge CLK) disable iff (!nRST)
    (wb_valid && !wb_ready) |=> $stable(wb_pr) && $stable(wb_rob_index))
    else $error("writeback tags not held under back-pressure");

  a_pass_pr: assert property (@(posedge CLK) disable iff (!nRST)
    (hist_v[2] && &free_q) |-> wb_valid && wb_pr == hist_pr[2])
    else $error("wb_pr %0d, issued %0d three cycles earlier", wb_pr, hist_pr[2]);

  a_pass_rob: assert property (@(posedge CLK) disable iff (!nRST)
    (hist_v[2] && &free_q) |-> wb_valid && wb_rob_index == hist_rob[2])
    else $error("wb_rob_index %0d, issued %0d three cycles earlier",
                wb_rob_index, hist_rob[2]);

endmodule

`default_nettype wire

/* src/alu_imm_top.sv */
// Immediate ALU pipeline top level joining register file, three stages and checker
`timescale 1ns/1ps
`default_nettype none

module alu_imm_top (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     issue_valid,
  input  alu_imm_pkg::alu_imm_op_e issue_op,
  input  logic [11:0]              issue_imm12,
  input  core_types_pkg::pr_t      issue_a_pr,
  input  logic                     issue_a_is_zero,
  input  core_types_pkg::pr_t      issue_dest_pr,
  input  core_types_pkg::rob_idx_t issue_rob_index,
  output logic                     issue_ready,
  input  logic                     prf_wr_en,
  input  core_types_pkg::pr_t      prf_wr_pr,
  input  core_types_pkg::word_t    prf_wr_data,
  input  logic                     wb_ready,
  output logic                     wb_valid,
  output core_types_pkg::word_t    wb_data,
  output core_types_pkg::pr_t      wb_pr,
  output core_types_pkg::rob_idx_t wb_rob_index
);

  core_types_pkg::pr_t   rd_pr;
  core_types_pkg::word_t rd_data;
  logic                  stall;

  alu_pipe_if #(.payload_t(alu_imm_pkg::issue_pkt_t)) issue_to_exec ();
  alu_pipe_if #(.payload_t(alu_imm_pkg::exec_pkt_t))  exec_to_wb ();

  // One stall fanned to every stage
  assign issue_to_exec.stall = stall;
  assign exec_to_wb.stall    = stall;

  prf_banked u_prf (
    .CLK     (CLK),
    .nRST    (nRST),
    .wr_en   (prf_wr_en),
    .wr_pr   (prf_wr_pr),
    .wr_data (prf_wr_data),
    .rd_pr   (rd_pr),
    .rd_data (rd_data)
  );

  alu_imm_issue u_issue (
    .CLK             (CLK),
    .nRST            (nRST),
    .issue_valid     (issue_valid),
    .issue_op        (issue_op),
    .issue_imm12     (issue_imm12),
    .issue_a_pr      (issue_a_pr),
    .issue_a_is_zero (issue_a_is_zero),
    .issue_dest_pr   (issue_dest_pr),
    .issue_rob_index (issue_rob_index),
    .issue_ready     (issue_ready),
    .rd_pr           (rd_pr),
    .out             (issue_to_exec.src)
  );

  alu_imm_execute u_execute (
    .CLK     (CLK),
    .nRST    (nRST),
    .rd_data (rd_data),
    .in      (issue_to_exec.dst),
    .out     (exec_to_wb.src)
  );

  alu_imm_writeback u_writeback (
    .CLK          (CLK),
    .nRST         (nRST),
    .in           (exec_to_wb.dst),
    .wb_ready     (wb_ready),
    .wb_valid     (wb_valid),
    .wb_data      (wb_data),
    .wb_pr        (wb_pr),
    .wb_rob_index (wb_rob_index),
    .stall        (stall)
  );

  alu_imm_pipeline_sva u_sva (
    .CLK             (CLK),
    .nRST            (nRST),
    .issue_valid     (issue_valid),
    .issue_ready     (issue_ready),
    .issue_dest_pr   (issue_dest_pr),
    .issue_rob_index (issue_rob_index),
    .wb_valid        (wb_valid),
    .wb_ready        (wb_ready),
    .wb_data         (wb_data),
    .wb_pr           (wb_pr),
    .wb_rob_index    (wb_rob_index)
  );

endmodule

`default_nettype wire

/* test/alu_imm_tb.sv */
// Testbench for the immediate ALU pipeline with reference model, LFSR stimulus and timeout
`timescale 1ns/1ps
`default_nettype none
`include "core_cfg.svh"

module alu_imm_tb;

  // Issues per test: 36 + 1 + 9 + 40 + 16
  localparam int N_ISSUES       = 102;
  localparam int TIMEOUT_CYCLES = 40 * N_ISSUES + 200;

  logic                     CLK;
  logic                     nRST;
  logic                     issue_valid;
  alu_imm_pkg::alu_imm_op_e issue_op;
  logic [11:0]              issue_imm12;
  core_types_pkg::pr_t      issue_a_pr;
  logic                     issue_a_is_zero;
  core_types_pkg::pr_t      issue_dest_pr;
  core_types_pkg::rob_idx_t issue_rob_index;
  logic                     issue_ready;
  logic                     prf_wr_en;
  core_types_pkg::pr_t      prf_wr_pr;
  core_types_pkg::word_t    prf_wr_data;
  logic                     wb_ready;
  logic                     wb_valid;
  core_types_pkg::word_t    wb_data;
  core_types_pkg::pr_t      wb_pr;
  core_types_pkg::rob_idx_t wb_rob_index;

  // Expected results in issue order
  core_types_pkg::word_t    exp_data [$];
  core_types_pkg::pr_t      exp_pr [$];
  core_types_pkg::rob_idx_t exp_rob [$];

  // Mirror of the register file contents
  core_types_pkg::word_t    prf_model [`PR_COUNT];
  alu_imm_pkg::alu_imm_op_e op_list [9] = '{alu_imm_pkg::ADDI, alu_imm_pkg::SLTI,
    alu_imm_pkg::SLTIU, alu_imm_pkg::XORI, alu_imm_pkg::ORI, alu_imm_pkg::ANDI,
    alu_imm_pkg::SLLI, alu_imm_pkg::SRLI, alu_imm_pkg::SRAI};

  logic [31:0]              lfsr_state = 32'h9036_8e05;
  string                    test_name = "reset state";
  int                       n_checks = 0;
  int                       n_errors = 0;
  int                       n_pass = 0;
  int                       n_fail = 0;
  int                       test_err0 = 0;
  int                       cycles = 0;
  int                       n_wb = 0;
  int                       last_wb_cycle = 0;
  logic                     rand_ready = 1'b0;
  core_types_pkg::rob_idx_t next_rob = '0;
  logic                     held = 1'b0;
  core_types_pkg::word_t    held_data;
  core_types_pkg::pr_t      held_pr;
  core_types_pkg::rob_idx_t held_rob;

  alu_imm_top uut (
    .CLK             (CLK),
    .nRST            (nRST),
    .issue_valid     (issue_valid),
    .issue_op        (issue_op),
    .issue_imm12     (issue_imm12),
    .issue_a_pr      (issue_a_pr),
    .issue_a_is_zero (issue_a_is_zero),
    .issue_dest_pr   (issue_dest_pr),
    .issue_rob_index (issue_rob_index),
    .issue_ready     (issue_ready),
    .prf_wr_en       (prf_wr_en),
    .prf_wr_pr       (prf_wr_pr),
    .prf_wr_data     (prf_wr_data),
    .wb_ready        (wb_ready),
    .wb_valid        (wb_valid),
    .wb_data         (wb_data),
    .wb_pr           (wb_pr),
    .wb_rob_index    (wb_rob_index)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Right-shifting Galois LFSR, taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic rand_bit();
    logic [31:0] v;
    v = rand_bits(1);
    return v[0];
  endfunction

  function automatic core_types_pkg::pr_t rand_pr();
    logic [31:0] v;
    v = rand_bits(`LOG_PR_COUNT);
    return v[`LOG_PR_COUNT-1:0];
  endfunction

  function automatic logic [11:0] rand_imm();
    logic [31:0] v;
    v = rand_bits(12);
    return v[11:0];
  endfunction

  // Expected result from the RV32I immediate semantics
  function automatic core_types_pkg::word_t alu_imm_ref(input alu_imm_pkg::alu_imm_op_e op,
                                                        input core_types_pkg::word_t a,
                                                        input logic [11:0] imm);
    core_types_pkg::word_t sx;
    core_types_pkg::word_t r;
    logic [4:0]            sh;
    sx = imm[11] ? {20'hf_ffff, imm} : {20'h0_0000, imm};
    sh = imm[4:0];
    case (op)
      alu_imm_pkg::ADDI:  r = a + sx;
      // Signed compare done as unsigned with both sign bits flipped
      alu_imm_pkg::SLTI:  r = ((a ^ 32'h8000_0000) < (sx ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
      alu_imm_pkg::SLTIU: r = (a < sx) ? 32'd1 : 32'd0;
      alu_imm_pkg::XORI:  r = a ^ sx;
      alu_imm_pkg::ORI:   r = a | sx;
      alu_imm_pkg::ANDI:  r = a & sx;
      alu_imm_pkg::SLLI:  r = a << sh;
      alu_imm_pkg::SRLI:  r = a >> sh;
      alu_imm_pkg::SRAI: begin
        r = a >> sh;
        if (a[31]) r = r | ~(32'hffff_ffff >> sh);
      end
      default:            r = 32'd0;
    endcase
    return r;
  endfunction

  task automatic check_word(input string what, input core_types_pkg::word_t exp,
                            input core_types_pkg::word_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_pr(input string what, input core_types_pkg::pr_t exp,
                          input core_types_pkg::pr_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_rob(input string what, input core_types_pkg::rob_idx_t exp,
                           input core_types_pkg::rob_idx_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input int exp, input int act);
    n_checks++;
    if (exp != act) begin
      n_errors++;
      $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = n_errors;
  endtask

  task automatic end_test();
    if (n_errors == test_err0) begin
      n_pass++;
      $display("PASS %s", test_name);
    end else begin
      n_fail++;
      $display("FAIL %s (%0d errors)", test_name, n_errors - test_err0);
    end
  endtask

  task automatic drive_ready();
    if (rand_ready) wb_ready = rand_bit();
    else wb_ready = 1'b1;
  endtask

  // Edge values in the low registers for compare and shift corner cases
  task automatic preload_prf();
    core_types_pkg::word_t v;
    for (int i = 0; i < `PR_COUNT; i++) begin
      case (i)
        0:       v = 32'h8000_0000;
        1:       v = 32'h7fff_ffff;
        2:       v = 32'hffff_ffff;
        3:       v = 32'h0000_0000;
        default: v = rand_bits(32);
      endcase
      @(negedge CLK);
      prf_wr_en   = 1'b1;
      prf_wr_pr   = core_types_pkg::pr_t'(i);
      prf_wr_data = v;
      prf_model[i] = v;
    end
    @(negedge CLK);
    prf_wr_en = 1'b0;
  endtask

  // Presents one instruction and returns on the edge that accepts it
  task automatic issue_one(input alu_imm_pkg::alu_imm_op_e op, input logic [11:0] imm,
                           input core_types_pkg::pr_t a_pr, input logic a_zero);
    core_types_pkg::word_t a;
    core_types_pkg::pr_t   dest;
    dest = rand_pr();
    a = a_zero ? '0 : prf_model[a_pr];
    @(negedge CLK);
    drive_ready();
    issue_valid     = 1'b1;
    issue_op        = op;
    issue_imm12     = imm;
    issue_a_pr      = a_pr;
    issue_a_is_zero = a_zero;
    issue_dest_pr   = dest;
    issue_rob_index = next_rob;
    exp_data.push_back(alu_imm_ref(op, a, imm));
    exp_pr.push_back(dest);
    exp_rob.push_back(next_rob);
    next_rob = next_rob + 1'b1;
    @(posedge CLK);
    while (!issue_ready) begin
      @(negedge CLK);
      drive_ready();
      @(posedge CLK);
    end
  endtask

  task automatic drain();
    @(negedge CLK);
    issue_valid = 1'b0;
    drive_ready();
    while (exp_data.size() != 0) begin
      @(negedge CLK);
      drive_ready();
    end
    rand_ready = 1'b0;
    wb_ready   = 1'b1;
  endtask

  // Writeback monitor, values sampled are those settled during the past cycle
  always @(posedge CLK) begin
    if (nRST) begin
      if (held) begin
        check_bit("wb_valid under stall", 1'b1, wb_valid);
        check_word("wb_data under stall", held_data, wb_data);
        check_pr("wb_pr under stall", held_pr, wb_pr);
        check_rob("wb_rob_index under stall", held_rob, wb_rob_index);
      end
      if (wb_valid && !wb_ready) begin
        check_bit("issue_ready under stall", 1'b0, issue_ready);
      end
      if (wb_valid && wb_ready) begin
        if (exp_data.size() == 0) begin
          n_errors++;
          $display("Unexpected writeback in %s with no instruction outstanding", test_name);
        end else begin
          check_word("wb_data", exp_data.pop_front(), wb_data);
          check_pr("wb_pr", exp_pr.pop_front(), wb_pr);
          check_rob("wb_rob_index", exp_rob.pop_front(), wb_rob_index);
        end
        n_wb++;
        last_wb_cycle = cycles;
      end
      held      = wb_valid && !wb_ready;
      held_data = wb_data;
      held_pr   = wb_pr;
      held_rob  = wb_rob_index;
    end
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles with %0d results outstanding", cycles, exp_data.size());
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    int                  lat;
    int                  c0;
    int                  wb0;
    int                  k;
    core_types_pkg::pr_t a_pr;
    logic [11:0]         imm;
    nRST            = 1'b0;
    issue_valid     = 1'b0;
    issue_op        = alu_imm_pkg::ADDI;
    issue_imm12     = '0;
    issue_a_pr      = '0;
    issue_a_is_zero = 1'b0;
    issue_dest_pr   = '0;
    issue_rob_index = '0;
    prf_wr_en       = 1'b0;
    prf_wr_pr       = '0;
    prf_wr_data     = '0;
    wb_ready        = 1'b1;
    c0              = 0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;

    start_test("reset state");
    @(posedge CLK);
    check_bit("wb_valid", 1'b0, wb_valid);
    check_bit("issue_ready", 1'b1, issue_ready);
    end_test();

    preload_prf();
    start_test("every operation");
    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < 9; i++) begin
        case (r)
          0:       imm = 12'h800;
          1:       imm = 12'hfff;
          2:       imm = 12'h7ff;
          default: imm = rand_imm();
        endcase
        a_pr = (r < 3) ? core_types_pkg::pr_t'(r) : rand_pr();
        issue_one(op_list[i], imm, a_pr, 1'b0);
      end
    end
    drain();
    end_test();

    start_test("fixed latency");
    imm  = rand_imm();
    a_pr = rand_pr();
    issue_one(alu_imm_pkg::ADDI, imm, a_pr, 1'b0);
    lat = 0;
    do begin
      @(negedge CLK);
      issue_valid = 1'b0;
      @(posedge CLK);
      lat++;
    end while (!wb_valid && lat < 8);
    check_count("cycles from issue to wb_valid", 3, lat);
    drain();
    end_test();

    // Register 2 holds all ones, so any leak of the operand shows
    start_test("zero source");
    for (int i = 0; i < 9; i++) begin
      imm = rand_imm();
      issue_one(op_list[i], imm, core_types_pkg::pr_t'(2), 1'b1);
    end
    drain();
    end_test();

    start_test("back-pressure");
    rand_ready = 1'b1;
    for (int i = 0; i < 40; i++) begin
      k    = int'(rand_bits(4)) % 9;
      imm  = rand_imm();
      a_pr = rand_pr();
      issue_one(op_list[k], imm, a_pr, 1'b0);
    end
    drain();
    end_test();

    start_test("throughput");
    wb0 = n_wb;
    for (int i = 0; i < 16; i++) begin
      imm  = rand_imm();
      a_pr = rand_pr();
      issue_one(op_list[i % 9], imm, a_pr, 1'b0);
      if (i == 0) c0 = cycles;
    end
    drain();
    check_count("writebacks", 16, n_wb - wb0);
    // Sixteen results in the sixteen cycles right after the pipeline fills
    check_count("cycles to last writeback", 18, last_wb_cycle - c0);
    end_test();

    $display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
             n_pass, n_fail, n_checks, n_errors);
    if (n_errors == 0 && n_fail == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
src/core_types_pkg.sv
src/alu_imm_pkg.sv
src/alu_pipe_if.sv
src/prf_banked.sv
src/alu_imm_issue.sv
src/alu_imm_execute.sv
src/alu_imm_writeback.sv
src/alu_imm_pipeline_sva.sv
src/alu_imm_top.sv
test/alu_imm_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := alu_imm_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
PASS_MSG  := Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
